// ==== include/huff_consts.svh ====
`ifndef HUFF_CONSTS_SVH
`define HUFF_CONSTS_SVH

// Tree dimensions
`define HUFF_LEAVES      16
`define HUFF_IDX_W       4
`define HUFF_FREQ_W      16
`define HUFF_SUM_W       20
`define HUFF_NODE_W      5
`define HUFF_NODES       31

// APB bus widths
`define APB_ADDR_W       8
`define APB_DATA_W       32

// Register map in byte offsets
`define REG_CTRL         8'h00
`define REG_STATUS       8'h04
`define REG_ROOT         8'h08
`define REG_LEAF_BASE    8'h40
`define REG_TREE_BASE    8'h80

`endif

// ==== source/huff_tree_pkg.sv ====
`include "huff_consts.svh"

package huff_tree_pkg;

	////////////////////////////////////////
	// Sorted list entry
	////////////////////////////////////////

	// Node number on top, frequency below
	typedef struct packed {
		logic [`HUFF_NODE_W-1:0] node;
		logic [`HUFF_SUM_W-1:0]  freq;
	} sorted_frame_t;

	////////////////////////////////////////
	// Parent link entry
	////////////////////////////////////////

	// side 0 is the smaller (left) child
	typedef struct packed {
		logic                    side;
		logic [`HUFF_NODE_W-1:0] parent;
	} link_entry_t;

	// Build engine FSM
	typedef enum logic [2:0] {
		IDLE,
		NODE_READ,
		NODE_MERGE,
		NODE_SKIP,
		NODE_SEEK,
		NODE_INSERT,
		TREE_DONE
	} engine_state_t;

endpackage

// ==== source/huff_apb_pkg.sv ====
package huff_apb_pkg;

	// Register class of the current APB address
	typedef enum logic [2:0] {
		NONE,
		CTRL,
		STATUS,
		ROOT,
		LEAF,
		TREE
	} reg_sel_t;

	////////////////////////////////////////
	// Register field positions
	////////////////////////////////////////

	localparam int CTRL_START_BIT  = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;
	// Root node sits above the 20-bit frequency
	localparam int ROOT_NODE_LSB   = 24;
	localparam int TREE_VALID_BIT  = 8;
	localparam int TREE_SIDE_BIT   = 5;

endpackage

// ==== source/apb_reg_decode.sv ====
`timescale 1ns/1ps
`include "huff_consts.svh"

module apb_reg_decode
	import huff_tree_pkg::*;
	import huff_apb_pkg::*;
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`APB_ADDR_W-1:0]  paddr,
	input  logic [`APB_DATA_W-1:0]  pwdata,
	input  logic                    busy,
	input  logic                    done,
	input  logic [`HUFF_NODE_W-1:0] root_node,
	input  logic [`HUFF_SUM_W-1:0]  root_freq,
	input  logic                    rd_valid,
	input  link_entry_t             rd_entry,
	output logic [`APB_DATA_W-1:0]  prdata,
	output logic                    pready,
	output logic                    leaf_we,
	output logic [`HUFF_IDX_W-1:0]  leaf_idx,
	output logic [`HUFF_FREQ_W-1:0] leaf_freq,
	output logic                    build_start,
	output logic [`HUFF_NODE_W-1:0] rd_addr
);

	reg_sel_t sel;
	logic     aligned;
	logic     access;
	logic     wr_acc;
	logic     rd_wait;

	////////////////////////////////////////
	// Address decode
	////////////////////////////////////////

	assign aligned = paddr[1:0] == 2'b00;

	always_comb
	begin
		sel = NONE;
		if (!aligned)
			sel = NONE;
		else if (paddr == `REG_CTRL)
			sel = CTRL;
		else if (paddr == `REG_STATUS)
			sel = STATUS;
		else if (paddr == `REG_ROOT)
			sel = ROOT;
		else if (paddr >= `REG_LEAF_BASE && paddr < `REG_LEAF_BASE + 4 * `HUFF_LEAVES)
			sel = LEAF;
		else if (paddr >= `REG_TREE_BASE && paddr < `REG_TREE_BASE + 4 * `HUFF_NODES)
			sel = TREE;
	end

	assign access = psel & penable;
	assign wr_acc = access & pwrite;

	// Link store read is registered, so a TREE read waits one cycle
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			rd_wait <= 1'b0;
		else
			rd_wait <= access & ~pwrite & (sel == TREE) & ~rd_wait;
	end

	assign pready = access & (pwrite | (sel != TREE) | rd_wait);

	// Word offset inside the 0x80 window
	assign rd_addr = paddr[6:2];

	////////////////////////////////////////
	// Write strobes toward the engine
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			leaf_we     <= 1'b0;
			build_start <= 1'b0;
		end
		else
		begin
			leaf_we     <= wr_acc & (sel == LEAF);
			build_start <= wr_acc & (sel == CTRL) & pwdata[CTRL_START_BIT];
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_acc && sel == LEAF)
		begin
			leaf_idx  <= paddr[5:2];
			leaf_freq <= pwdata[`HUFF_FREQ_W-1:0];
		end
	end

	// Unmapped and write-only words read 0
	always_comb
	begin
		prdata = '0;
		case (sel)
			STATUS:
			begin
				prdata[STATUS_BUSY_BIT] = busy;
				prdata[STATUS_DONE_BIT] = done;
			end
			ROOT:
			begin
				prdata[ROOT_NODE_LSB +: `HUFF_NODE_W] = root_node;
				prdata[`HUFF_SUM_W-1:0]               = root_freq;
			end
			TREE:
			begin
				// Empty entries read as all zero
				if (rd_valid)
				begin
					prdata[TREE_VALID_BIT]     = 1'b1;
					prdata[TREE_SIDE_BIT]      = rd_entry.side;
					prdata[`HUFF_NODE_W-1:0]   = rd_entry.parent;
				end
			end
			default:
				prdata = '0;
		endcase
	end

endmodule

// ==== source/tree_link_ram.sv ====
`timescale 1ns/1ps
`include "huff_consts.svh"

module tree_link_ram
	import huff_tree_pkg::*;
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    link_we,
	input  logic [`HUFF_NODE_W-1:0] link_addr,
	input  link_entry_t             link_data,
	input  logic                    link_clear,
	input  logic [`HUFF_NODE_W-1:0] rd_addr,
	output logic                    rd_valid,
	output link_entry_t             rd_entry
);

	link_entry_t            mem [`HUFF_NODES];
	logic [`HUFF_NODES-1:0] valid;
	logic                   rd_hit;

	// Node 31 does not exist
	assign rd_hit = rd_addr < `HUFF_NODES;

	always_ff @(posedge clk)
	begin
		if (link_we)
			mem[link_addr] <= link_data;
	end

	// Clearing the flags empties the whole store at once
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			valid <= '0;
		else if (link_clear)
			valid <= '0;
		else if (link_we)
			valid[link_addr] <= 1'b1;
	end

	////////////////////////////////////////
	// Registered read port
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_hit && valid[rd_addr];
	end

	always_ff @(posedge clk)
	begin
		rd_entry <= rd_hit ? mem[rd_addr] : '0;
	end

endmodule

// ==== source/huff_merge_engine.sv ====
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_merge_engine
	import huff_tree_pkg::*;
(
	input  logic                    clk,
	input  logic                    rstN,
	input  logic                    leaf_we,
	input  logic [`HUFF_IDX_W-1:0]  leaf_idx,
	input  logic [`HUFF_FREQ_W-1:0] leaf_freq,
	input  logic                    build_start,
	output logic                    busy,
	output logic                    done,
	output logic [`HUFF_NODE_W-1:0] root_node,
	output logic [`HUFF_SUM_W-1:0]  root_freq,
	output logic                    link_we,
	output logic [`HUFF_NODE_W-1:0] link_addr,
	output link_entry_t             link_data,
	output logic                    link_clear
);

	logic [`HUFF_FREQ_W-1:0] leaf_bank [`HUFF_LEAVES];
	sorted_frame_t           list [`HUFF_LEAVES];
	engine_state_t           state;
	engine_state_t           state_nxt;
	logic [`HUFF_IDX_W-1:0]  head;
	logic [`HUFF_IDX_W-1:0]  pos;
	logic [`HUFF_NODE_W-1:0] new_node;
	sorted_frame_t           cur_a;
	sorted_frame_t           cur_b;
	logic [`HUFF_SUM_W-1:0]  merge_freq;
	logic                    link_b_pend;
	logic                    accept;
	logic                    last_live;
	logic                    head_zero;
	logic [`HUFF_IDX_W:0]    probe;
	logic                    shift_ok;

	assign busy   = (state != IDLE) && (state != TREE_DONE);
	assign done   = state == TREE_DONE;
	assign accept = build_start & ~busy;

	// List always ends at the last slot, so one live entry means head at the end
	assign last_live  = head == `HUFF_IDX_W'(`HUFF_LEAVES - 1);
	assign head_zero  = list[head].freq == '0;
	assign merge_freq = cur_a.freq + cur_b.freq;

	////////////////////////////////////////
	// Insertion probe
	////////////////////////////////////////

	// Hole is head+1 after a merge; probe looks one past the hole
	assign probe = (state == NODE_MERGE) ? head + 2 : pos + 2;
	// Equal entries move ahead of the merged node
	assign shift_ok = (probe < `HUFF_LEAVES) &&
		(list[probe[`HUFF_IDX_W-1:0]].freq <= merge_freq);

	// Host leaf bank, frozen during a build
	always_ff @(posedge clk)
	begin
		if (leaf_we && !busy)
			leaf_bank[leaf_idx] <= leaf_freq;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE, TREE_DONE:
				if (accept)
					state_nxt = NODE_READ;
			NODE_READ:
				if (last_live)
					state_nxt = TREE_DONE;
				else if (head_zero)
					state_nxt = NODE_SKIP;
				else
					state_nxt = NODE_MERGE;
			NODE_SKIP:
				state_nxt = NODE_READ;
			NODE_MERGE, NODE_SEEK:
				state_nxt = shift_ok ? NODE_SEEK : NODE_INSERT;
			NODE_INSERT:
				state_nxt = NODE_READ;
			default:
				state_nxt = IDLE;
		endcase
	end

	////////////////////////////////////////
	// Sorted list
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			for (int i = 0; i < `HUFF_LEAVES; i++)
			begin
				list[i].node <= `HUFF_NODE_W'(i);
				list[i].freq <= `HUFF_SUM_W'(leaf_bank[i]);
			end
		end
		else if (state == NODE_SEEK)
			list[pos] <= list[pos + 1'b1];
		else if (state == NODE_INSERT)
		begin
			list[pos].node <= new_node;
			list[pos].freq <= merge_freq;
		end
	end

	// Two smallest live entries
	always_ff @(posedge clk)
	begin
		if (state == NODE_READ)
		begin
			cur_a <= list[head];
			cur_b <= list[head + 1'b1];
		end
	end

	// Head, hole position and node counter
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			head     <= '0;
			pos      <= '0;
			new_node <= '0;
		end
		else if (accept)
		begin
			head     <= '0;
			pos      <= '0;
			new_node <= `HUFF_NODE_W'(`HUFF_LEAVES);
		end
		else
		begin
			case (state)
				NODE_SKIP:
					head <= head + 1'b1;
				NODE_MERGE:
				begin
					head <= head + 1'b1;
					pos  <= head + 1'b1;
				end
				NODE_SEEK:
					pos <= pos + 1'b1;
				NODE_INSERT:
					new_node <= new_node + 1'b1;
				default:
					head <= head;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			link_b_pend <= 1'b0;
			link_clear  <= 1'b0;
			root_node   <= '0;
			root_freq   <= '0;
		end
		else
		begin
			link_b_pend <= state == NODE_MERGE;
			link_clear  <= accept;
			// All-zero input reports node 0 as the root
			if (state == NODE_READ && last_live)
			begin
				root_node <= head_zero ? '0 : list[head].node;
				root_freq <= list[head].freq;
			end
		end
	end

	// Left child in the merge cycle, right child one cycle later
	assign link_we          = (state == NODE_MERGE) | link_b_pend;
	assign link_addr        = link_b_pend ? cur_b.node : cur_a.node;
	assign link_data.side   = link_b_pend;
	assign link_data.parent = new_node;

endmodule

// ==== source/huff_tree_top.sv ====
`timescale 1ns/1ps
`include "huff_consts.svh"

module huff_tree_top
	import huff_tree_pkg::*;
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic [`APB_DATA_W-1:0] pwdata,
	output logic [`APB_DATA_W-1:0] prdata,
	output logic                   pready
);

	// Decode to engine
	logic                    leaf_we;
	logic [`HUFF_IDX_W-1:0]  leaf_idx;
	logic [`HUFF_FREQ_W-1:0] leaf_freq;
	logic                    build_start;

	// Engine status back to decode
	logic                    busy;
	logic                    done;
	logic [`HUFF_NODE_W-1:0] root_node;
	logic [`HUFF_SUM_W-1:0]  root_freq;

	// Link store traffic
	logic                    link_we;
	logic [`HUFF_NODE_W-1:0] link_addr;
	link_entry_t             link_data;
	logic                    link_clear;
	logic [`HUFF_NODE_W-1:0] rd_addr;
	logic                    rd_valid;
	link_entry_t             rd_entry;

	apb_reg_decode u_decode (
		.clk(clk), .rstN(rstN),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.busy(busy), .done(done),
		.root_node(root_node), .root_freq(root_freq),
		.rd_valid(rd_valid), .rd_entry(rd_entry),
		.prdata(prdata), .pready(pready),
		.leaf_we(leaf_we), .leaf_idx(leaf_idx), .leaf_freq(leaf_freq),
		.build_start(build_start), .rd_addr(rd_addr)
	);

	huff_merge_engine u_engine (
		.clk(clk), .rstN(rstN),
		.leaf_we(leaf_we), .leaf_idx(leaf_idx), .leaf_freq(leaf_freq),
		.build_start(build_start),
		.busy(busy), .done(done),
		.root_node(root_node), .root_freq(root_freq),
		.link_we(link_we), .link_addr(link_addr), .link_data(link_data),
		.link_clear(link_clear)
	);

	tree_link_ram u_links (
		.clk(clk), .rstN(rstN),
		.link_we(link_we), .link_addr(link_addr), .link_data(link_data),
		.link_clear(link_clear), .rd_addr(rd_addr),
		.rd_valid(rd_valid), .rd_entry(rd_entry)
	);

endmodule

// ==== sim/huff_tree_assertions.sv ====
`timescale 1ns/1ps

module huff_tree_assertions (
	input logic clk,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic build_start,
	input logic busy,
	input logic done,
	input logic link_we
);

	////////////////////////////////////////
	// APB side
	////////////////////////////////////////

	// Ready only inside an access phase
	assert property (@(posedge clk) disable iff (!rstN) pready |-> (psel && penable))
		else $error("pready high outside an APB access phase");

	// Start strobe lasts one cycle
	assert property (@(posedge clk) disable iff (!rstN) build_start |=> !build_start)
		else $error("build_start held for more than one cycle");

	////////////////////////////////////////
	// Engine side
	////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rstN) !(busy && done))
		else $error("busy and done high together");

	// Links are only written by a running build
	assert property (@(posedge clk) disable iff (!rstN) link_we |-> busy)
		else $error("link_we while the engine is idle");

endmodule

// Decode has no link port, engine has no APB pins
bind apb_reg_decode huff_tree_assertions u_decode_checks (
	.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pready(pready),
	.build_start(build_start), .busy(busy), .done(done), .link_we(1'b0)
);

bind huff_merge_engine huff_tree_assertions u_engine_checks (
	.clk(clk), .rstN(rstN), .psel(1'b0), .penable(1'b0), .pready(1'b0),
	.build_start(build_start), .busy(busy), .done(done), .link_we(link_we)
);

// ==== sim/tb_huff_tree.sv ====
`timescale 1ns/1ps
`include "huff_consts.svh"

module tb_huff_tree;

	localparam int ROWS       = 7;
	localparam int APB_WAITS  = 8;
	localparam int DONE_POLLS = 300;

	logic        clk;
	logic        rstN;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;

	// Stimulus table of 16 sorted leaves per row and the expected root
	logic [15:0] stim_freq [ROWS][16];
	logic [4:0]  exp_node [ROWS];
	logic [19:0] exp_freq [ROWS];

	// Reference model results
	logic [4:0]  mdl_parent [31];
	logic        mdl_side [31];
	logic        mdl_valid [31];
	logic [4:0]  mdl_root_node;
	logic [19:0] mdl_root_freq;

	logic [31:0] lfsr;
	int          errors;
	int          timeouts;

	huff_tree_top DUT (
		.clk(clk), .rstN(rstN),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// APB master
	////////////////////////////////////////

	task automatic apb_access(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waits;
		int exp_waits;
		waits = 0;
		// Only a TREE read waits for the registered link store
		exp_waits = (!wr && addr >= `REG_TREE_BASE &&
			addr < `REG_TREE_BASE + 4 * `HUFF_NODES) ? 1 : 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		while (!pready && waits < APB_WAITS)
		begin
			waits++;
			@(posedge clk);
		end
		if (!pready)
		begin
			timeouts++;
			$display("Timeout: APB transfer to address %h never saw pready", addr);
		end
		else if (waits != exp_waits)
		begin
			errors++;
			$display("Error at %0t: APB transfer to address %h took %0d wait states, expected %0d",
				$time, addr, waits, exp_waits);
		end
		rdata = prdata;
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_access(1'b0, addr, 32'h0, data);
	endtask

	// Poll STATUS until the done bit rises
	task automatic wait_done();
		logic [31:0] st;
		int          polls;
		st    = '0;
		polls = 0;
		while (!st[1] && polls < DONE_POLLS)
		begin
			apb_read(`REG_STATUS, st);
			polls++;
		end
		if (!st[1])
		begin
			timeouts++;
			$display("Timeout: build did not finish within %0d status polls", polls);
		end
		else if (st[0])
		begin
			errors++;
			$display("Error at %0t: STATUS shows busy together with done", $time);
		end
	endtask

	////////////////////////////////////////
	// Random leaves
	////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
		return val;
	endfunction

	task automatic sort_row(input int r);
		logic [15:0] tmp;
		for (int i = 0; i < 15; i++)
			for (int j = 0; j < 15 - i; j++)
				if (stim_freq[r][j] > stim_freq[r][j + 1])
				begin
					tmp                 = stim_freq[r][j];
					stim_freq[r][j]     = stim_freq[r][j + 1];
					stim_freq[r][j + 1] = tmp;
				end
	endtask

	task automatic fill_table();
		int          nz;
		logic [19:0] sum;
		stim_freq[0] = '{16{16'd5}};
		stim_freq[1] = '{0, 0, 0, 0, 0, 1, 1, 2, 3, 5, 8, 13, 21, 34, 55, 89};
		stim_freq[2] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 700};
		stim_freq[3] = '{16{16'd0}};
		stim_freq[4] = '{1, 1, 1, 1, 1, 1, 1, 1, 2, 4, 8, 16, 64, 256, 4096, 65535};
		exp_node = '{30, 25, 15, 0, 30, 0, 0};
		exp_freq = '{80, 232, 700, 0, 69989, 0, 0};
		for (int r = 5; r < ROWS; r++)
		begin
			for (int i = 0; i < 16; i++)
				stim_freq[r][i] = 16'(take_bits(10));
			sort_row(r);
			nz  = 0;
			sum = '0;
			for (int i = 0; i < 16; i++)
				if (stim_freq[r][i] != 0)
				begin
					nz++;
					sum += stim_freq[r][i];
				end
			// n live leaves need n-1 merges
			exp_node[r] = (nz > 1) ? 5'(14 + nz) : ((nz == 1) ? 5'd15 : 5'd0);
			exp_freq[r] = sum;
		end
	endtask

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	task automatic run_model(input int r);
		logic [4:0]  qn [$];
		logic [19:0] qf [$];
		logic [4:0]  na;
		logic [4:0]  nb;
		logic [4:0]  nn;
		logic [19:0] sum;
		int          pos;
		for (int i = 0; i < 31; i++)
			mdl_valid[i] = 1'b0;
		for (int i = 0; i < 16; i++)
		begin
			qn.push_back(5'(i));
			qf.push_back(20'(stim_freq[r][i]));
		end
		while (qn.size() > 1 && qf[0] == 0)
		begin
			void'(qn.pop_front());
			void'(qf.pop_front());
		end
		nn = 5'd16;
		while (qn.size() > 1)
		begin
			na  = qn.pop_front();
			nb  = qn.pop_front();
			sum = qf.pop_front();
			sum = sum + qf.pop_front();
			mdl_parent[na] = nn;
			mdl_side[na]   = 1'b0;
			mdl_valid[na]  = 1'b1;
			mdl_parent[nb] = nn;
			mdl_side[nb]   = 1'b1;
			mdl_valid[nb]  = 1'b1;
			// New node goes behind every equal entry
			pos = 0;
			while (pos < qf.size() && qf[pos] <= sum)
				pos++;
			qn.insert(pos, nn);
			qf.insert(pos, sum);
			nn++;
		end
		mdl_root_node = (qf[0] == 0) ? 5'd0 : qn[0];
		mdl_root_freq = qf[0];
	endtask

	task automatic check_row(input int r);
		logic [31:0] rdata;
		logic [31:0] exp;
		if (mdl_root_node !== exp_node[r] || mdl_root_freq !== exp_freq[r])
		begin
			errors++;
			$display("Error at %0t: row %0d model root %0d/%0d differs from table %0d/%0d",
				$time, r, mdl_root_node, mdl_root_freq, exp_node[r], exp_freq[r]);
		end
		exp        = '0;
		exp[28:24] = exp_node[r];
		exp[19:0]  = exp_freq[r];
		apb_read(`REG_ROOT, rdata);
		if (rdata !== exp)
		begin
			errors++;
			$display("Error at %0t: row %0d ROOT read %h, expected %h", $time, r, rdata, exp);
		end
		for (int n = 0; n < `HUFF_NODES; n++)
		begin
			exp = '0;
			if (mdl_valid[n])
			begin
				exp[8]   = 1'b1;
				exp[5]   = mdl_side[n];
				exp[4:0] = mdl_parent[n];
			end
			apb_read(8'(`REG_TREE_BASE + 4 * n), rdata);
			if (rdata !== exp)
			begin
				errors++;
				$display("Error at %0t: row %0d TREE[%0d] read %h, expected %h",
					$time, r, n, rdata, exp);
			end
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		rstN     = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		errors   = 0;
		timeouts = 0;
		lfsr     = 32'hef4b_356d;
		fill_table();
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		// Idle state after reset
		apb_read(`REG_STATUS, rdata);
		if (rdata !== 32'h0)
		begin
			errors++;
			$display("Error at %0t: STATUS after reset reads %h", $time, rdata);
		end
		apb_read(`REG_ROOT, rdata);
		if (rdata !== 32'h0)
		begin
			errors++;
			$display("Error at %0t: ROOT after reset reads %h", $time, rdata);
		end
		for (int n = 0; n < `HUFF_NODES; n++)
		begin
			apb_read(8'(`REG_TREE_BASE + 4 * n), rdata);
			if (rdata !== 32'h0)
			begin
				errors++;
				$display("Error at %0t: TREE[%0d] after reset reads %h", $time, n, rdata);
			end
		end

		for (int r = 0; r < ROWS; r++)
		begin
			run_model(r);
			for (int i = 0; i < 16; i++)
				apb_write(8'(`REG_LEAF_BASE + 4 * i), 32'(stim_freq[r][i]));
			apb_write(`REG_CTRL, 32'h1);
			apb_read(`REG_STATUS, rdata);
			if (rdata[1:0] !== 2'b01)
			begin
				errors++;
				$display("Error at %0t: row %0d STATUS after start reads %h", $time, r, rdata);
			end
			// Host traffic during the build
			apb_write(`REG_LEAF_BASE, 32'hffff);
			apb_write(`REG_CTRL, 32'h1);
			wait_done();
			check_row(r);
			// Tie order in the all-equal row
			if (r == 0 && (mdl_parent[16] !== 5'd24 || mdl_side[16] !== 1'b0 ||
				mdl_parent[17] !== 5'd24 || mdl_side[17] !== 1'b1))
			begin
				errors++;
				$display("Error at %0t: model links of nodes 16 and 17 break the tie rule", $time);
			end
		end

		// Rebuild from the untouched leaf bank
		apb_write(`REG_CTRL, 32'h1);
		wait_done();
		check_row(ROWS - 1);

		$display("Errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+include
source/huff_tree_pkg.sv
source/huff_apb_pkg.sv
source/apb_reg_decode.sv
source/tree_link_ram.sv
source/huff_merge_engine.sv
source/huff_tree_top.sv
sim/huff_tree_assertions.sv
sim/tb_huff_tree.sv
